// File: hw/tia_pkg.sv
// TIA package: shared widths, opcodes, operand and destination kinds, instruction formats.
package tia_pkg;

    localparam int word_width = 32;
    localparam int tag_width = 2;
    localparam int num_registers = 8;
    localparam int num_predicates = 8;
    localparam int max_channels = 4;
    localparam int immediate_width = 16;

    typedef logic [$clog2(num_registers) - 1:0] reg_index_t;
    typedef logic [$clog2(max_channels) - 1:0] chan_index_t;

    typedef enum logic [4:0] {
        nop, mov, add, sub, and_op, or_op, xor_op, sll, srl, eq, lt, halt
    } opcode_e;

    typedef enum logic [1:0] {src_none, src_imm, src_reg, src_chan} source_e;

    typedef enum logic [1:0] {dst_none, dst_reg, dst_pred, dst_chan} dest_e;

    typedef struct packed {
        logic [tag_width - 1:0] tag;
        logic [word_width - 1:0] data;
    } packet_t;

    typedef struct packed {
        logic valid;
        packet_t packet;
    } link_t;

    // Channel masks cover the largest configuration; bits past the channel count stay zero.
    typedef struct packed {
        logic valid;
        logic [num_predicates - 1:0] true_mask;
        logic [num_predicates - 1:0] false_mask;
        logic [max_channels - 1:0] input_mask;
        chan_index_t tag_channel;
        logic tag_check;
        logic [tag_width - 1:0] tag;
        chan_index_t out_channel;
        logic out_use;
    } trigger_t;

    typedef struct packed {
        logic vi;
        opcode_e op;
        source_e st0;
        reg_index_t si0;
        source_e st1;
        reg_index_t si1;
        dest_e dt;
        reg_index_t di;
        chan_index_t oci;
        logic [tag_width - 1:0] oct;
        logic [max_channels - 1:0] icd;
        logic [num_predicates - 1:0] pred_set;
        logic [num_predicates - 1:0] pred_clear;
        logic [immediate_width - 1:0] immediate;
    } datapath_instruction_t;

    typedef struct packed {
        trigger_t trigger;
        datapath_instruction_t datapath;
    } instruction_t;

endpackage

// File: hw/channel_buffer.sv
// Channel buffer: circular FIFO of tagged packets for input and output channels.
`timescale 1ns/1ps

module channel_buffer
    import tia_pkg::*;
#(
    parameter int buffer_depth = 4
) (
    input  logic clock,
    input  logic rst,
    input  logic push,
    input  packet_t push_packet,
    input  logic pop,
    output packet_t head,
    output logic empty,
    output logic full,
    output logic [$clog2(buffer_depth + 1) - 1:0] count
);
    localparam int count_width = $clog2(buffer_depth + 1);
    localparam int ptr_width = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;

    packet_t entries [buffer_depth - 1:0];
    logic [ptr_width - 1:0] read_ptr;
    logic [ptr_width - 1:0] write_ptr;

    function automatic logic [ptr_width - 1:0] advance(input logic [ptr_width - 1:0] ptr);
        return (ptr == ptr_width'(buffer_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clock) begin
        if (rst) begin
            read_ptr <= '0;
            write_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                write_ptr <= advance(write_ptr);
            end
            if (pop) begin
                read_ptr <= advance(read_ptr);
            end
            count <= count + count_width'(push) - count_width'(pop);
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[write_ptr] <= push_packet;
        end
    end

    assign head = entries[read_ptr];
    assign empty = (count == '0);
    assign full = (count == count_width'(buffer_depth));

    // Producers and consumers must honour the flags.
    assert property (@(posedge clock) disable iff (rst) !(push && full));
    assert property (@(posedge clock) disable iff (rst) !(pop && empty));

endmodule

// File: hw/instruction_memory.sv
// Instruction memory: loadable slots exposing every trigger and the selected datapath word.
`timescale 1ns/1ps

module instruction_memory
    import tia_pkg::*;
#(
    parameter int num_instructions = 8
) (
    input  logic clock,
    input  logic rst,
    input  logic load_strobe,
    input  logic [$clog2(num_instructions) - 1:0] load_index,
    input  instruction_t load_instruction,
    output trigger_t triggers [num_instructions - 1:0],
    input  logic issue_valid,
    input  logic [$clog2(num_instructions) - 1:0] issue_index,
    output datapath_instruction_t issued
);
    datapath_instruction_t datapath [num_instructions - 1:0];

    // Reset invalidates every slot.
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < num_instructions; i++) begin
                triggers[i].valid <= 1'b0;
            end
        end else if (load_strobe) begin
            triggers[load_index] <= load_instruction.trigger;
        end
    end

    always_ff @(posedge clock) begin
        if (load_strobe) begin
            datapath[load_index] <= load_instruction.datapath;
        end
    end

    always_comb begin
        issued = '0;
        if (issue_valid) begin
            issued = datapath[issue_index];
        end
    end

endmodule

// File: hw/trigger_resolution_unit.sv
// Trigger resolution: picks the lowest-index instruction whose trigger is satisfied.
`timescale 1ns/1ps

module trigger_resolution_unit
    import tia_pkg::*;
#(
    parameter int num_input_channels = 2,
    parameter int num_output_channels = 2,
    parameter int num_instructions = 8
) (
    input  logic execute,
    input  logic halted,
    input  trigger_t triggers [num_instructions - 1:0],
    input  logic [num_predicates - 1:0] predicates,
    input  logic [num_input_channels - 1:0] in_empty,
    input  logic [tag_width - 1:0] in_tags [num_input_channels - 1:0],
    input  logic [num_output_channels - 1:0] out_full,
    input  datapath_instruction_t x_instruction,
    output logic issue_valid,
    output logic [$clog2(num_instructions) - 1:0] issue_index
);
    localparam int index_width = $clog2(num_instructions);

    logic [max_channels - 1:0] empty_all;
    logic [max_channels - 1:0] blocked;
    logic [tag_width - 1:0] tags_all [max_channels - 1:0];
    logic [num_instructions - 1:0] ready;
    logic hazard;

    // Missing channels look empty and full.
    always_comb begin
        empty_all = '1;
        blocked = '1;
        for (int c = 0; c < max_channels; c++) begin
            tags_all[c] = '0;
        end
        for (int c = 0; c < num_input_channels; c++) begin
            empty_all[c] = in_empty[c];
            tags_all[c] = in_tags[c];
        end
        for (int c = 0; c < num_output_channels; c++) begin
            blocked[c] = out_full[c];
        end
        // A pending enqueue counts as a full slot.
        if (x_instruction.vi && x_instruction.dt == dst_chan) begin
            blocked[x_instruction.oci] = 1'b1;
        end
    end

    // Predicate writes and halts in X stall issue for one cycle.
    assign hazard = x_instruction.vi
                    && (x_instruction.dt == dst_pred || x_instruction.op == halt);

    for (genvar i = 0; i < num_instructions; i++) begin : g_ready
        assign ready[i] = triggers[i].valid
            && ((predicates & triggers[i].true_mask) == triggers[i].true_mask)
            && ((~predicates & triggers[i].false_mask) == triggers[i].false_mask)
            && ((triggers[i].input_mask & empty_all) == '0)
            && (!triggers[i].tag_check
                || (!empty_all[triggers[i].tag_channel]
                    && tags_all[triggers[i].tag_channel] == triggers[i].tag))
            && (!triggers[i].out_use || !blocked[triggers[i].out_channel]);
    end

    always_comb begin
        issue_valid = 1'b0;
        issue_index = '0;
        if (execute && !halted && !hazard) begin
            for (int i = num_instructions - 1; i >= 0; i--) begin
                if (ready[i]) begin
                    issue_valid = 1'b1;
                    issue_index = index_width'(i);
                end
            end
        end
    end

endmodule

// File: hw/predicate_unit.sv
// Predicate unit: predicate register with issue-time masks and X-stage writes.
`timescale 1ns/1ps

module predicate_unit
    import tia_pkg::*;
(
    input  logic clock,
    input  logic rst,
    input  datapath_instruction_t issued,
    input  datapath_instruction_t x_instruction,
    input  logic [word_width - 1:0] x_result,
    output logic [num_predicates - 1:0] predicates
);
    logic [num_predicates - 1:0] next_predicates;

    always_comb begin
        next_predicates = predicates;
        if (issued.vi) begin
            next_predicates = (next_predicates | issued.pred_set) & ~issued.pred_clear;
        end
        // X write wins.
        if (x_instruction.vi && x_instruction.dt == dst_pred) begin
            next_predicates[x_instruction.di] = x_result[0];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            predicates <= '0;
        end else begin
            predicates <= next_predicates;
        end
    end

endmodule

// File: hw/operand_unit.sv
// Operand unit: register file, source fetch and forwarding from the X stage.
`timescale 1ns/1ps

module operand_unit
    import tia_pkg::*;
#(
    parameter int num_input_channels = 2
) (
    input  logic clock,
    input  logic rst,
    input  datapath_instruction_t issued,
    input  logic [word_width - 1:0] in_data [num_input_channels - 1:0],
    input  datapath_instruction_t x_instruction,
    input  logic [word_width - 1:0] x_result,
    output logic [word_width - 1:0] operand_0,
    output logic [word_width - 1:0] operand_1
);
    logic [word_width - 1:0] registers [num_registers - 1:0];
    logic [word_width - 1:0] chan_data [max_channels - 1:0];
    logic x_writes_reg;

    assign x_writes_reg = x_instruction.vi && x_instruction.dt == dst_reg;

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int r = 0; r < num_registers; r++) begin
                registers[r] <= '0;
            end
        end else if (x_writes_reg) begin
            registers[x_instruction.di] <= x_result;
        end
    end

    // Absent channels read as zero.
    always_comb begin
        for (int c = 0; c < max_channels; c++) begin
            chan_data[c] = '0;
        end
        for (int c = 0; c < num_input_channels; c++) begin
            chan_data[c] = in_data[c];
        end
    end

    function automatic logic [word_width - 1:0] fetch(input source_e st, input reg_index_t si);
        logic [word_width - 1:0] value;
        value = '0;
        case (st)
            src_imm: value = {{(word_width - immediate_width){1'b0}}, issued.immediate};
            src_reg: begin
                // Bypass the write that lands at this edge.
                if (x_writes_reg && x_instruction.di == si) begin
                    value = x_result;
                end else begin
                    value = registers[si];
                end
            end
            src_chan: value = chan_data[si[$bits(chan_index_t) - 1:0]];
            default: value = '0;
        endcase
        return value;
    endfunction

    always_comb begin
        operand_0 = fetch(issued.st0, issued.si0);
        operand_1 = fetch(issued.st1, issued.si1);
    end

endmodule

// File: hw/functional_unit.sv
// Functional unit: single-cycle arithmetic, logic, shift and compare operations.
`timescale 1ns/1ps

module functional_unit
    import tia_pkg::*;
(
    input  opcode_e op,
    input  logic [word_width - 1:0] operand_0,
    input  logic [word_width - 1:0] operand_1,
    output logic [word_width - 1:0] result
);
    localparam int shift_width = $clog2(word_width);

    logic [shift_width - 1:0] shamt;

    assign shamt = operand_1[shift_width - 1:0];

    always_comb begin
        case (op)
            mov:    result = operand_0;
            add:    result = operand_0 + operand_1;
            sub:    result = operand_0 - operand_1;
            and_op: result = operand_0 & operand_1;
            or_op:  result = operand_0 | operand_1;
            xor_op: result = operand_0 ^ operand_1;
            sll:    result = operand_0 << shamt;
            srl:    result = operand_0 >> shamt;
            // Unsigned compares give one or zero.
            eq:     result = {{(word_width - 1){1'b0}}, operand_0 == operand_1};
            lt:     result = {{(word_width - 1){1'b0}}, operand_0 < operand_1};
            default: result = '0;
        endcase
    end

endmodule

// File: hw/td_x_core.sv
// TD|X core: triggered-instruction processing element with channel buffers and two stages.
`timescale 1ns/1ps

module td_x_core
    import tia_pkg::*;
#(
    parameter int num_input_channels = 2,
    parameter int num_output_channels = 2,
    parameter int buffer_depth = 4,
    parameter int num_instructions = 8
) (
    input  logic clock,
    input  logic rst,
    input  logic execute,
    output logic halted,
    output logic channels_quiescent,
    input  logic load_strobe,
    input  logic [$clog2(num_instructions) - 1:0] load_index,
    input  instruction_t load_instruction,
    input  link_t in_links [num_input_channels - 1:0],
    output logic [num_input_channels - 1:0] in_ready,
    output link_t out_links [num_output_channels - 1:0],
    input  logic [num_output_channels - 1:0] out_ready
);
    localparam int count_width = $clog2(buffer_depth + 1);

    packet_t in_head [num_input_channels - 1:0];
    logic [tag_width - 1:0] in_tags [num_input_channels - 1:0];
    logic [word_width - 1:0] in_data [num_input_channels - 1:0];
    logic [count_width - 1:0] in_count [num_input_channels - 1:0];
    logic [num_input_channels - 1:0] in_empty, in_full, in_dequeue, in_idle;

    packet_t out_head [num_output_channels - 1:0];
    logic [num_output_channels - 1:0] out_empty, out_full, out_enqueue;
    packet_t x_packet;

    trigger_t triggers [num_instructions - 1:0];
    logic issue_valid;
    logic [$clog2(num_instructions) - 1:0] issue_index;
    datapath_instruction_t issued, x_instruction;
    logic [num_predicates - 1:0] predicates;
    logic [word_width - 1:0] operand_0, operand_1, x_operand_0, x_operand_1, x_result;

    for (genvar i = 0; i < num_input_channels; i++) begin : g_in
        channel_buffer #(.buffer_depth(buffer_depth)) icb (
            .clock(clock),
            .rst(rst),
            .push(in_links[i].valid && in_ready[i]),
            .push_packet(in_links[i].packet),
            .pop(in_dequeue[i]),
            .head(in_head[i]),
            .empty(in_empty[i]),
            .full(in_full[i]),
            .count(in_count[i])
        );
        assign in_ready[i] = !in_full[i];
        assign in_tags[i] = in_head[i].tag;
        assign in_data[i] = in_head[i].data;
        assign in_dequeue[i] = issued.vi && issued.icd[i];
        assign in_idle[i] = (in_count[i] == '0);
    end

    assign x_packet = {x_instruction.oct, x_result};

    for (genvar c = 0; c < num_output_channels; c++) begin : g_out
        channel_buffer #(.buffer_depth(buffer_depth)) ocb (
            .clock(clock),
            .rst(rst),
            .push(out_enqueue[c]),
            .push_packet(x_packet),
            .pop(out_links[c].valid && out_ready[c]),
            .head(out_head[c]),
            .empty(out_empty[c]),
            .full(out_full[c]),
            .count()
        );
        assign out_enqueue[c] = x_instruction.vi && x_instruction.dt == dst_chan
                                && x_instruction.oci == chan_index_t'(c);
        assign out_links[c] = {!out_empty[c], out_head[c]};
    end

    instruction_memory #(.num_instructions(num_instructions)) im (
        .clock(clock), .rst(rst),
        .load_strobe(load_strobe), .load_index(load_index), .load_instruction(load_instruction),
        .triggers(triggers), .issue_valid(issue_valid), .issue_index(issue_index), .issued(issued)
    );

    trigger_resolution_unit #(
        .num_input_channels(num_input_channels),
        .num_output_channels(num_output_channels),
        .num_instructions(num_instructions)
    ) tru (
        .execute(execute), .halted(halted), .triggers(triggers), .predicates(predicates),
        .in_empty(in_empty), .in_tags(in_tags), .out_full(out_full),
        .x_instruction(x_instruction), .issue_valid(issue_valid), .issue_index(issue_index)
    );

    predicate_unit pu (
        .clock(clock), .rst(rst), .issued(issued), .x_instruction(x_instruction),
        .x_result(x_result), .predicates(predicates)
    );

    operand_unit #(.num_input_channels(num_input_channels)) ou (
        .clock(clock), .rst(rst), .issued(issued), .in_data(in_data),
        .x_instruction(x_instruction), .x_result(x_result),
        .operand_0(operand_0), .operand_1(operand_1)
    );

    // TD|X pipeline register.
    always_ff @(posedge clock) begin
        if (rst) begin
            x_instruction <= '0;
        end else begin
            x_instruction <= issued;
        end
    end

    always_ff @(posedge clock) begin
        x_operand_0 <= operand_0;
        x_operand_1 <= operand_1;
    end

    functional_unit fu (
        .op(x_instruction.op), .operand_0(x_operand_0), .operand_1(x_operand_1),
        .result(x_result)
    );

    // Sticky until reset.
    always_ff @(posedge clock) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (x_instruction.vi && x_instruction.op == halt) begin
            halted <= 1'b1;
        end
    end

    assign channels_quiescent = (&in_idle) && (&out_empty);

    // Program loads only while the core is stopped.
    assert property (@(posedge clock) disable iff (rst) load_strobe |-> !execute);

endmodule

// File: verif/tb_td_x_core.sv
// Testbench for the TD|X core: loads a program, streams packets and checks output packets.
`timescale 1ns/1ps

module tb_td_x_core
    import tia_pkg::*;
();
    localparam int num_in = 2;
    localparam int num_out = 2;
    localparam int depth = 4;
    localparam int num_instr = 8;
    localparam int index_width = $clog2(num_instr);
    localparam int stim_words = 512;
    localparam int max_packets = 32;
    localparam int max_cycles = 3000;

    logic clock, rst, execute, halted, channels_quiescent, load_strobe;
    logic [index_width - 1:0] load_index;
    instruction_t load_instruction;
    link_t in_links [num_in - 1:0];
    logic [num_in - 1:0] in_ready;
    link_t out_links [num_out - 1:0];
    logic [num_out - 1:0] out_ready;

    logic [31:0] stim [stim_words];
    instruction_t prog_words [num_instr];
    logic [index_width - 1:0] prog_slots [num_instr];
    packet_t in_pkts [num_in][max_packets];
    packet_t exp_pkts [num_out][max_packets];
    int in_len [num_in];
    int in_pos [num_in];
    int exp_len [num_out];
    int exp_pos [num_out];
    logic [num_in - 1:0] in_taken;
    int prog_len, error_count, wait_cycles, seed;

    td_x_core #(
        .num_input_channels(num_in), .num_output_channels(num_out),
        .buffer_depth(depth), .num_instructions(num_instr)
    ) UUT (
        .clock(clock), .rst(rst), .execute(execute), .halted(halted),
        .channels_quiescent(channels_quiescent), .load_strobe(load_strobe),
        .load_index(load_index), .load_instruction(load_instruction),
        .in_links(in_links), .in_ready(in_ready), .out_links(out_links), .out_ready(out_ready)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s (got 0x%0h, expected 0x%0h)",
                     $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("TEST FAILED");
        $fatal(1, "Run aborted.");
    endtask

    function automatic instruction_t make_instruction(input int b);
        instruction_t w;
        w = '0;
        w.trigger.valid = stim[b][0];
        w.trigger.true_mask = stim[b + 1][num_predicates - 1:0];
        w.trigger.false_mask = stim[b + 2][num_predicates - 1:0];
        w.trigger.input_mask = stim[b + 3][max_channels - 1:0];
        w.trigger.tag_channel = chan_index_t'(stim[b + 4]);
        w.trigger.tag_check = stim[b + 5][0];
        w.trigger.tag = stim[b + 6][tag_width - 1:0];
        w.trigger.out_channel = chan_index_t'(stim[b + 7]);
        w.trigger.out_use = stim[b + 8][0];
        w.datapath.vi = stim[b + 9][0];
        w.datapath.op = opcode_e'(stim[b + 10][4:0]);
        w.datapath.st0 = source_e'(stim[b + 11][1:0]);
        w.datapath.si0 = reg_index_t'(stim[b + 12]);
        w.datapath.st1 = source_e'(stim[b + 13][1:0]);
        w.datapath.si1 = reg_index_t'(stim[b + 14]);
        w.datapath.dt = dest_e'(stim[b + 15][1:0]);
        w.datapath.di = reg_index_t'(stim[b + 16]);
        w.datapath.oci = chan_index_t'(stim[b + 17]);
        w.datapath.oct = stim[b + 18][tag_width - 1:0];
        w.datapath.icd = stim[b + 19][max_channels - 1:0];
        w.datapath.pred_set = stim[b + 20][num_predicates - 1:0];
        w.datapath.pred_clear = stim[b + 21][num_predicates - 1:0];
        w.datapath.immediate = stim[b + 22][immediate_width - 1:0];
        return w;
    endfunction

    // Records are variable length, keyed by their first word.
    task automatic parse_stimulus();
        int p;
        int c;
        logic done;
        p = 0;
        done = 1'b0;
        while (!done && p < stim_words) begin
            c = stim[p + 1];
            case (stim[p])
                32'h1: begin
                    if (prog_len >= num_instr) begin
                        abort_run("the data file holds too many program slots");
                    end
                    prog_slots[prog_len] = stim[p + 1][index_width - 1:0];
                    prog_words[prog_len] = make_instruction(p + 2);
                    prog_len++;
                    p += 25;
                end
                32'h2: begin
                    if (c >= num_in || in_len[c] >= max_packets) begin
                        abort_run("an input packet line names a bad channel or overflows it");
                    end
                    in_pkts[c][in_len[c]] = {stim[p + 2][tag_width - 1:0], stim[p + 3]};
                    in_len[c]++;
                    p += 4;
                end
                32'h3: begin
                    if (c >= num_out || exp_len[c] >= max_packets) begin
                        abort_run("an expected packet line names a bad channel or overflows it");
                    end
                    exp_pkts[c][exp_len[c]] = {stim[p + 2][tag_width - 1:0], stim[p + 3]};
                    exp_len[c]++;
                    p += 4;
                end
                32'h0: done = 1'b1;
                default: abort_run("the data file holds an unknown record kind");
            endcase
        end
        if (!done) begin
            abort_run("the data file has no end record");
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clock);
            load_strobe <= 1'b1;
            load_index <= prog_slots[i];
            load_instruction <= prog_words[i];
        end
        @(posedge clock);
        load_strobe <= 1'b0;
    endtask

    task automatic collect_output(input int c, input packet_t pkt);
        if (exp_pos[c] >= exp_len[c]) begin
            check_value(exp_pos[c] + 1, exp_len[c],
                        $sformatf("packet count on output channel %0d", c));
        end else begin
            check_value(pkt.tag, exp_pkts[c][exp_pos[c]].tag,
                        $sformatf("tag of packet %0d on output channel %0d", exp_pos[c], c));
            check_value(pkt.data, exp_pkts[c][exp_pos[c]].data,
                        $sformatf("data of packet %0d on output channel %0d", exp_pos[c], c));
            exp_pos[c]++;
        end
    endtask

    // Drive at the rising edge, then sample the handshakes at the falling edge.
    task automatic run_cycle();
        @(posedge clock);
        for (int c = 0; c < num_in; c++) begin
            if (in_taken[c]) begin
                in_pos[c]++;
            end
            if (in_taken[c] || !in_links[c].valid) begin
                if (in_pos[c] < in_len[c] && ($urandom % 4) != 0) begin
                    in_links[c] <= {1'b1, in_pkts[c][in_pos[c]]};
                end else begin
                    in_links[c] <= '0;
                end
            end
        end
        for (int c = 0; c < num_out; c++) begin
            out_ready[c] <= ($urandom % 3) != 0;
        end
        @(negedge clock);
        for (int c = 0; c < num_in; c++) begin
            in_taken[c] = in_links[c].valid && in_ready[c];
        end
        for (int c = 0; c < num_out; c++) begin
            if (out_links[c].valid && out_ready[c]) begin
                collect_output(c, out_links[c].packet);
            end
        end
    endtask

    function automatic logic all_received();
        logic done;
        done = 1'b1;
        for (int c = 0; c < num_out; c++) begin
            done = done && (exp_pos[c] == exp_len[c]);
        end
        return done;
    endfunction

    task automatic check_outputs_idle(input string when);
        for (int c = 0; c < num_out; c++) begin
            check_value(out_links[c].valid, 1'b0,
                        $sformatf("output %0d valid %s", c, when));
        end
    endtask

    initial begin
        seed = $urandom(84375);
        rst = 1'b1;
        execute = 1'b0;
        load_strobe = 1'b0;
        load_index = '0;
        load_instruction = '0;
        out_ready = '0;
        in_taken = '0;
        error_count = 0;
        prog_len = 0;
        for (int c = 0; c < num_in; c++) begin
            in_links[c] = '0;
            in_len[c] = 0;
            in_pos[c] = 0;
        end
        for (int c = 0; c < num_out; c++) begin
            exp_len[c] = 0;
            exp_pos[c] = 0;
        end
        $readmemh("verif/tb_program_input.txt", stim);
        parse_stimulus();

        repeat (4) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        check_value(halted, 1'b0, "halted after reset");
        check_value(channels_quiescent, 1'b1, "channels_quiescent after reset");
        check_value(in_ready, {num_in{1'b1}}, "in_ready after reset");
        check_outputs_idle("after reset");

        load_program();
        @(negedge clock);
        check_outputs_idle("after program load");
        check_value(channels_quiescent, 1'b1, "channels_quiescent after program load");
        @(posedge clock);
        execute <= 1'b1;
        @(negedge clock);

        wait_cycles = 0;
        while (!all_received()) begin
            run_cycle();
            wait_cycles++;
            if (wait_cycles > max_cycles) begin
                abort_run("timed out waiting for the expected output packets");
            end
        end
        wait_cycles = 0;
        while (!halted) begin
            run_cycle();
            wait_cycles++;
            if (wait_cycles > max_cycles) begin
                abort_run("timed out waiting for the core to halt");
            end
        end
        wait_cycles = 0;
        while (!channels_quiescent) begin
            run_cycle();
            wait_cycles++;
            if (wait_cycles > max_cycles) begin
                abort_run("timed out waiting for the channels to drain");
            end
        end

        // A halted core must stay silent.
        repeat (20) run_cycle();
        check_value(halted, 1'b1, "halted after the drain window");
        check_value(channels_quiescent, 1'b1, "channels_quiescent after the drain window");

        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/tia_pkg.sv
hw/channel_buffer.sv
hw/instruction_memory.sv
hw/trigger_resolution_unit.sv
hw/predicate_unit.sv
hw/operand_unit.sv
hw/functional_unit.sv
hw/td_x_core.sv
verif/tb_td_x_core.sv

// File: Bender.yml
package:
  name: td_x_core

sources:
  - hw/tia_pkg.sv
  - hw/channel_buffer.sv
  - hw/instruction_memory.sv
  - hw/trigger_resolution_unit.sv
  - hw/predicate_unit.sv
  - hw/operand_unit.sv
  - hw/functional_unit.sv
  - hw/td_x_core.sv
  - target: simulation
    files:
      - verif/tb_td_x_core.sv

// File: verif/tb_program_input.txt
// kind 1: idx | tv tmask fmask imask tchan tchk ttag ochan ouse | vi op st0 si0 st1 si1 dt di oci oct icd set clr imm
// kind 2: input chan tag data; kind 3: expected output chan tag data; kind 0: end of file
1 0  1 00 03 1 0 1 3 0 0  1 b 0 0 0 0 0 0 0 0 1 00 00 0000
1 1  1 00 03 3 0 1 0 0 0  1 2 3 0 3 1 1 1 0 0 3 01 00 0000
1 2  1 01 02 0 0 0 0 0 1  1 1 2 1 0 0 3 0 0 1 0 02 00 0000
1 3  1 03 00 0 0 0 0 0 0  1 a 2 1 1 0 2 2 0 0 0 00 01 0064
1 4  1 06 01 0 0 0 0 1 1  1 7 2 1 1 0 3 0 1 2 0 00 02 0001
1 5  1 02 05 0 0 0 0 1 1  1 3 2 1 1 0 3 0 1 3 0 00 02 0064
2 0 0 00000010
2 1 1 00000020
2 0 0 00000050
2 1 1 00000030
2 0 0 00000031
2 1 1 00000032
2 0 0 00000040
2 1 1 00000024
2 0 0 12345678
2 1 1 11111111
2 0 0 fffffff0
2 1 1 00000020
// Tag 3 on channel 0 is the halt request.
2 0 3 00000000
3 0 1 00000030
3 1 2 00000060
3 0 1 00000080
3 1 3 0000001c
3 0 1 00000063
3 1 2 000000c6
3 0 1 00000064
3 1 3 00000000
3 0 1 23456789
3 1 3 23456725
3 0 1 00000010
3 1 2 00000020
0
